// File: filelist.f
verilog/trace_pkg.sv
verilog/packed_log_if.sv
verilog/skid_buffer.sv
verilog/log_merge2.sv
verilog/trace_cfg_regs.sv
verilog/trace_pack_top.sv
bench/trace_pack_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and decide on the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module trace_pack_tb -Mdir obj_dir -o trace_pack_sim > build.log 2>&1 &&
./obj_dir/trace_pack_sim > sim.log 2>&1 ||
echo "build or simulation stopped early, see build.log and sim.log"
grep -q "^STATUS: PASS$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: bench/trace_pack_tb.sv
`timescale 1ns/1ps

module trace_pack_tb;

  // one expected packed word, data already cut at len
  typedef struct packed {
    logic [trace_pkg::full_width-1:0] data;
    logic [trace_pkg::len_width-1:0]  len;
    logic [trace_pkg::num_chan-1:0]   mask;
  } exp_t;

  logic                             clk;
  logic                             rstn;
  logic [trace_pkg::num_chan-1:0]   in_valid;
  logic [trace_pkg::full_width-1:0] in_data;
  logic                             in_ready;
  logic                             out_valid;
  logic [trace_pkg::full_width-1:0] out_data;
  logic [trace_pkg::len_width-1:0]  out_len;
  logic [trace_pkg::num_chan-1:0]   out_mask;
  logic                             out_ready;
  logic                             cfg_we;
  logic                             cfg_re;
  trace_pkg::cfg_addr_e             cfg_addr;
  logic [31:0]                      cfg_wdata;
  logic [31:0]                      cfg_rdata;

  // accepted records not yet seen on the output
  exp_t                             exp_q [$];
  exp_t                             head;
  // enable mask as the DUT should hold it
  logic [trace_pkg::num_chan-1:0]   en_shadow;
  logic [31:0]                      rng_state;
  logic [31:0]                      bp_state;
  logic                             bp_done;
  string                            test_name;
  int                               errors;
  int                               checks;
  int                               cycle_count;

  trace_pack_top u_dut (
    .clk (clk), .rstn (rstn),
    .in_valid (in_valid), .in_data (in_data), .in_ready (in_ready),
    .out_valid (out_valid), .out_data (out_data), .out_len (out_len),
    .out_mask (out_mask), .out_ready (out_ready),
    .cfg_we (cfg_we), .cfg_re (cfg_re), .cfg_addr (cfg_addr),
    .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // valid records stacked from bit 0 upward in channel order
  function automatic exp_t model_word(input logic [trace_pkg::num_chan-1:0] v,
                                      input logic [trace_pkg::full_width-1:0] d);
    exp_t                             e;
    int                               pos;
    logic [trace_pkg::full_width-1:0] field;
    e   = '0;
    pos = 0;
    for (int ch = 0; ch < trace_pkg::num_chan; ch++) begin
      if (v[ch]) begin
        field  = (d >> trace_pkg::chan_offset[ch])
               & ((64'd1 << trace_pkg::chan_width[ch]) - 64'd1);
        e.data = e.data | (field << pos);
        pos    = pos + trace_pkg::chan_width[ch];
      end
    end
    e.len  = pos[trace_pkg::len_width-1:0];
    e.mask = v;
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input exp_t e, input logic [trace_pkg::full_width-1:0] data,
                            input logic [trace_pkg::len_width-1:0] len,
                            input logic [trace_pkg::num_chan-1:0] mask);
    logic [trace_pkg::full_width-1:0] keep;
    // bits at or above len are don't-care
    keep   = (64'd1 << e.len) - 64'd1;
    checks = checks + 1;
    if (len !== e.len) begin
      errors = errors + 1;
      $display("error %s: len expected %0d actual %0d", test_name, e.len, len);
    end
    if ((data & keep) !== e.data) begin
      errors = errors + 1;
      $display("error %s: data expected %h actual %h", test_name, e.data, data & keep);
    end
    if (mask !== e.mask) begin
      errors = errors + 1;
      $display("error %s: mask expected %b actual %b", test_name, e.mask, mask);
    end
  endtask

  task automatic check_reg(input logic [31:0] expected, input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("error %s: reg expected %h actual %h", test_name, expected, actual);
    end
  endtask

  task automatic check_flag(input logic expected, input logic actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("error %s: flag expected %b actual %b", test_name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor, sampled mid-cycle where everything is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rstn) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("error %s: word on the output with no accepted record outstanding",
                   test_name);
        end else if (out_ready) begin
          head = exp_q.pop_front();
          check_word(head, out_data, out_len, out_mask);
        end
      end
      // disabled channels never reach the tree
      if (in_ready && ((in_valid & en_shadow) != '0)) begin
        exp_q.push_back(model_word(in_valid & en_shadow, in_data));
      end
    end
  end

  // run limit, well above the sum of all tests
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 4000) begin
      $display("timeout: run did not finish within 4000 cycles");
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////////////////////////

  // hold the record until an edge sees in_ready high
  task automatic send_record(input logic [trace_pkg::num_chan-1:0] v,
                             input logic [trace_pkg::full_width-1:0] d);
    logic ready_seen;
    in_valid   = v;
    in_data    = d;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      ready_seen = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = '0;
  endtask

  task automatic cfg_write(input trace_pkg::cfg_addr_e addr, input logic [31:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_we    = 1'b1;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    if (addr == trace_pkg::addr_enable) begin
      en_shadow = data[trace_pkg::num_chan-1:0];
    end
  endtask

  task automatic cfg_read(input trace_pkg::cfg_addr_e addr, output logic [31:0] value);
    cfg_addr = addr;
    cfg_re   = 1'b1;
    @(posedge clk);
    #1;
    cfg_re = 1'b0;
    value  = cfg_rdata;
  endtask

  // wait for the output to catch up, then a few idle cycles
  task automatic drain_words();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (3) begin
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    logic [31:0] value;
    test_name = "reset_values";
    check_flag(1'b0, out_valid);
    check_flag(1'b0, in_ready);
    cfg_read(trace_pkg::addr_enable, value);
    check_reg(32'hf, value);
    cfg_read(trace_pkg::addr_count, value);
    check_reg(32'h0, value);
  endtask

  // each channel alone, then all four, two cycles from drive to output
  task automatic single_and_all();
    logic [trace_pkg::num_chan-1:0] v;
    test_name = "single_and_all";
    for (int ch = 0; ch <= trace_pkg::num_chan; ch++) begin
      v = (ch < trace_pkg::num_chan) ? 4'(1 << ch) : '1;
      send_record(v, {next_rand(), next_rand()});
      check_flag(1'b0, out_valid);
      @(posedge clk);
      #1;
      check_flag(1'b1, out_valid);
    end
    drain_words();
  endtask

  task automatic random_subsets();
    logic [31:0] r;
    test_name = "random_subsets";
    repeat (300) begin
      r = next_rand();
      send_record(r[19:16], {next_rand(), next_rand()});
    end
    drain_words();
  endtask

  task automatic backpressure();
    logic [31:0] r;
    test_name = "backpressure";
    bp_state  = lcg_step(rng_state ^ 32'h5a5a_0f0f);
    bp_done   = 1'b0;
    fork
      begin
        repeat (150) begin
          r = next_rand();
          send_record(r[19:16], {next_rand(), next_rand()});
        end
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(posedge clk);
          #1;
          bp_state  = lcg_step(bp_state);
          out_ready = bp_state[16];
        end
      end
    join
    out_ready = 1'b1;
    drain_words();
  endtask

  // channels 1 and 3 off, a cycle with only those must give no word
  task automatic enable_mask();
    logic [31:0] value;
    test_name = "enable_mask";
    cfg_write(trace_pkg::addr_enable, 32'h5);
    cfg_read(trace_pkg::addr_enable, value);
    check_reg(32'h5, value);
    repeat (8) send_record('1, {next_rand(), next_rand()});
    repeat (4) send_record(4'ha, {next_rand(), next_rand()});
    send_record(4'h6, {next_rand(), next_rand()});
    drain_words();
    cfg_write(trace_pkg::addr_enable, 32'hf);
  endtask

  task automatic counter_clear();
    logic [31:0] value;
    logic [31:0] r;
    test_name = "counter_clear";
    cfg_write(trace_pkg::addr_clear, 32'h0);
    // every record nonzero so each gives exactly one word
    repeat (20) begin
      r = next_rand();
      send_record(r[19:16] | 4'h1, {next_rand(), next_rand()});
    end
    drain_words();
    cfg_read(trace_pkg::addr_count, value);
    check_reg(32'd20, value);
    cfg_write(trace_pkg::addr_clear, 32'h0);
    cfg_read(trace_pkg::addr_count, value);
    check_reg(32'h0, value);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstn        = 1'b1;
    in_valid    = '0;
    in_data     = '0;
    out_ready   = 1'b1;
    cfg_we      = 1'b0;
    cfg_re      = 1'b0;
    cfg_addr    = trace_pkg::addr_enable;
    cfg_wdata   = '0;
    en_shadow   = '1;
    rng_state   = 32'd98429;
    bp_state    = '0;
    bp_done     = 1'b0;
    test_name   = "init";
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b0;
    reset_values();
    single_and_all();
    random_subsets();
    backpressure();
    enable_mask();
    counter_clear();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/trace_pack_top.sv
`timescale 1ns/1ps

module trace_pack_top (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [trace_pkg::num_chan-1:0]    in_valid,
  input  logic [trace_pkg::full_width-1:0]  in_data,
  output logic                              in_ready,
  output logic                              out_valid,
  output logic [trace_pkg::full_width-1:0]  out_data,
  output logic [trace_pkg::len_width-1:0]   out_len,
  output logic [trace_pkg::num_chan-1:0]    out_mask,
  input  logic                              out_ready,
  input  logic                              cfg_we,
  input  logic                              cfg_re,
  input  trace_pkg::cfg_addr_e              cfg_addr,
  input  logic [31:0]                       cfg_wdata,
  output logic [31:0]                       cfg_rdata
);

  // leaf widths and their len widths
  localparam int w0  = trace_pkg::chan_width[0];
  localparam int w1  = trace_pkg::chan_width[1];
  localparam int w2  = trace_pkg::chan_width[2];
  localparam int w3  = trace_pkg::chan_width[3];
  localparam int lw0 = $clog2(w0 + 1);
  localparam int lw1 = $clog2(w1 + 1);
  localparam int lw2 = $clog2(w2 + 1);
  localparam int lw3 = $clog2(w3 + 1);

  logic [trace_pkg::num_chan-1:0]   enable;
  logic [trace_pkg::num_chan-1:0]   leaf_valid;
  logic [trace_pkg::tree_depth-1:0] ready_pipe;
  // mask pipeline
  logic                             mask_mid_valid;
  logic [trace_pkg::num_chan-1:0]   mask_mid;
  logic                             mask_mid_ready;
  logic                             mask_out_valid;

  //////////////////////////////////////////////////////////////////////
  // leaves
  //////////////////////////////////////////////////////////////////////

  packed_log_if #(.width(w0)) leaf0 ();
  packed_log_if #(.width(w1)) leaf1 ();
  packed_log_if #(.width(w2)) leaf2 ();
  packed_log_if #(.width(w3)) leaf3 ();

  // disabled channels look idle to the tree
  assign leaf_valid = in_valid & enable;

  assign leaf0.valid = leaf_valid[0];
  assign leaf0.data  = in_data[trace_pkg::chan_offset[0] +: w0];
  assign leaf0.len   = leaf_valid[0] ? lw0'(w0) : '0;
  assign leaf1.valid = leaf_valid[1];
  assign leaf1.data  = in_data[trace_pkg::chan_offset[1] +: w1];
  assign leaf1.len   = leaf_valid[1] ? lw1'(w1) : '0;
  assign leaf2.valid = leaf_valid[2];
  assign leaf2.data  = in_data[trace_pkg::chan_offset[2] +: w2];
  assign leaf2.len   = leaf_valid[2] ? lw2'(w2) : '0;
  assign leaf3.valid = leaf_valid[3];
  assign leaf3.data  = in_data[trace_pkg::chan_offset[3] +: w3];
  assign leaf3.len   = leaf_valid[3] ? lw3'(w3) : '0;

  //////////////////////////////////////////////////////////////////////
  // fixed two level merge tree
  //////////////////////////////////////////////////////////////////////

  packed_log_if #(.width(w0 + w1))               node01 ();
  packed_log_if #(.width(w2 + w3))               node23 ();
  packed_log_if #(.width(trace_pkg::full_width)) root ();

  // level 1, channels 0+1 and 2+3
  log_merge2 #(.width_a(w0), .width_b(w1)) u_merge01 (
    .clk (clk), .rstn (rstn), .a (leaf0), .b (leaf1), .y (node01)
  );
  log_merge2 #(.width_a(w2), .width_b(w3)) u_merge23 (
    .clk (clk), .rstn (rstn), .a (leaf2), .b (leaf3), .y (node23)
  );

  // level 2
  log_merge2 #(.width_a(w0 + w1), .width_b(w2 + w3)) u_merge_root (
    .clk (clk), .rstn (rstn), .a (node01), .b (node23), .y (root)
  );

  assign out_valid  = root.valid;
  assign out_data   = root.data;
  assign out_len    = root.len;
  assign root.ready = out_ready;

  // per-channel valid mask, one stage per merge level
  skid_buffer #(.width(trace_pkg::num_chan)) u_mask_l1 (
    .clk (clk), .rstn (rstn),
    .in_valid (|leaf_valid), .in_data (leaf_valid), .in_ready (),
    .out_valid (mask_mid_valid), .out_data (mask_mid), .out_ready (mask_mid_ready)
  );
  skid_buffer #(.width(trace_pkg::num_chan)) u_mask_l2 (
    .clk (clk), .rstn (rstn),
    .in_valid (mask_mid_valid), .in_data (mask_mid), .in_ready (mask_mid_ready),
    .out_valid (mask_out_valid), .out_data (out_mask), .out_ready (out_ready)
  );

  // input ready is out_ready delayed by the tree depth
  always_ff @(posedge clk) begin
    if (rstn) begin
      ready_pipe <= '0;
    end else begin
      ready_pipe <= {ready_pipe[trace_pkg::tree_depth-2:0], out_ready};
    end
  end
  assign in_ready = ready_pipe[trace_pkg::tree_depth-1];

  trace_cfg_regs u_cfg (
    .clk (clk), .rstn (rstn),
    .cfg_we (cfg_we), .cfg_re (cfg_re), .cfg_addr (cfg_addr),
    .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
    .word_fire (out_valid && out_ready), .enable (enable)
  );

  // mask pipeline must stay in step with the tree
  a_mask_sync : assert property (@(posedge clk) disable iff (rstn)
    mask_out_valid == out_valid);

endmodule

// File: verilog/trace_cfg_regs.sv
`timescale 1ns/1ps

module trace_cfg_regs (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            cfg_we,
  input  logic                            cfg_re,
  input  trace_pkg::cfg_addr_e            cfg_addr,
  input  logic [31:0]                     cfg_wdata,
  output logic [31:0]                     cfg_rdata,
  input  logic                            word_fire,
  output logic [trace_pkg::num_chan-1:0]  enable
);

  // packed words that left the subsystem
  logic [31:0] count;

  // enable mask and counter
  always_ff @(posedge clk) begin
    if (rstn) begin
      // every channel on after reset
      enable <= '1;
      count  <= '0;
    end else begin
      if (cfg_we && cfg_addr == trace_pkg::addr_enable) begin
        enable <= cfg_wdata[trace_pkg::num_chan-1:0];
      end
      // clear wins over a transfer in the same cycle
      if (cfg_we && cfg_addr == trace_pkg::addr_clear) begin
        count <= '0;
      end else if (word_fire) begin
        count <= count + 32'd1;
      end
    end
  end

  // registered read port, value held until the next read
  always_ff @(posedge clk) begin
    if (rstn) begin
      cfg_rdata <= '0;
    end else if (cfg_re) begin
      case (cfg_addr)
        trace_pkg::addr_enable: cfg_rdata <= 32'(enable);
        trace_pkg::addr_count:  cfg_rdata <= count;
        default:                cfg_rdata <= '0;
      endcase
    end
  end

  // host issues one access per cycle
  a_one_access : assert property (@(posedge clk) disable iff (rstn)
    !(cfg_we && cfg_re));

endmodule

// File: verilog/log_merge2.sv
`timescale 1ns/1ps

module log_merge2 #(
  parameter int width_a = 8,
  parameter int width_b = 8
) (
  input  logic       clk,
  input  logic       rstn,
  packed_log_if.cons a,
  packed_log_if.cons b,
  packed_log_if.prod y
);

  localparam int width_y = width_a + width_b;
  // len widths follow the bus rule
  localparam int lw_a = $clog2(width_a + 1);
  localparam int lw_b = $clog2(width_b + 1);
  localparam int lw_y = $clog2(width_y + 1);

  // buffered child A
  logic               a_q_valid;
  logic [width_a-1:0] a_q_data;
  logic [lw_a-1:0]    a_q_len;
  // buffered child B
  logic               b_q_valid;
  logic [width_b-1:0] b_q_data;
  logic [lw_b-1:0]    b_q_len;
  // lengths with invalid children forced to zero
  logic [lw_a-1:0]    len_a;
  logic [lw_b-1:0]    len_b;

  //////////////////////////////////////////////////////////////////////
  // one register stage per child
  //////////////////////////////////////////////////////////////////////

  // data and len ride together in one stage
  skid_buffer #(.width(width_a + lw_a)) u_buf_a (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (a.valid),
    .in_data   ({a.data, a.len}),
    .in_ready  (a.ready),
    .out_valid (a_q_valid),
    .out_data  ({a_q_data, a_q_len}),
    .out_ready (y.ready)
  );

  // both children share the parent's ready
  skid_buffer #(.width(width_b + lw_b)) u_buf_b (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (b.valid),
    .in_data   ({b.data, b.len}),
    .in_ready  (b.ready),
    .out_valid (b_q_valid),
    .out_data  ({b_q_data, b_q_len}),
    .out_ready (y.ready)
  );

  //////////////////////////////////////////////////////////////////////
  // packer
  //////////////////////////////////////////////////////////////////////

  assign y.valid = a_q_valid || b_q_valid;

  always_comb begin
    len_a = a_q_valid ? a_q_len : '0;
    len_b = b_q_valid ? b_q_len : '0;
    y.len = lw_y'(len_a) + lw_y'(len_b);
    // A at bit 0, cut at its length so stale upper bits can't leak into B
    // B starts right above A's last meaningful bit
    y.data = (width_y'(a_q_data) & ~({width_y{1'b1}} << len_a))
           | (width_y'(b_q_data) << len_a);
  end

  // merged length fits the combined width
  a_len_range : assert property (@(posedge clk) disable iff (rstn)
    y.valid |-> (int'(y.len) <= width_y));

endmodule

// File: verilog/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  logic [width-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [width-1:0] out_data,
  input  logic             out_ready
);

  // upstream ready is downstream ready one cycle late
  logic             ready_q;
  // main entry drives the output
  logic             main_valid;
  logic [width-1:0] main_data;
  // skid entry catches the one slot that arrives after a stall
  logic             skid_full;
  logic             skid_valid;
  logic [width-1:0] skid_data;

  // slots move on ready alone, so empty cycles keep their place too
  // sibling buffers with the same ready then stay in lockstep
  always_ff @(posedge clk) begin
    if (rstn) begin
      ready_q    <= 1'b0;
      main_valid <= 1'b0;
      skid_full  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      ready_q <= out_ready;
      if (out_ready) begin
        // main slot leaves, refill from skid first
        if (skid_full) begin
          main_valid <= skid_valid;
          skid_full  <= 1'b0;
        end else begin
          main_valid <= ready_q && in_valid;
        end
      end else if (ready_q) begin
        // output stalled but upstream still saw ready
        skid_full  <= 1'b1;
        skid_valid <= in_valid;
      end
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (out_ready) begin
      main_data <= skid_full ? skid_data : in_data;
    end else if (ready_q) begin
      skid_data <= in_data;
    end
  end

  assign in_ready  = ready_q;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  // a slot arriving must never find the skid entry still occupied
  // holds only while out_ready stays one cycle ahead of in_ready
  a_no_overflow : assert property (@(posedge clk) disable iff (rstn)
    ready_q |-> !skid_full);

endmodule

// File: verilog/packed_log_if.sv
`timescale 1ns/1ps

// packed record bus between merge tree nodes
interface packed_log_if #(
  parameter int width = 8
);

  // length field wide enough for 0 .. width
  localparam int len_w = $clog2(width + 1);

  // data and len only mean something while valid is high
  logic             valid;
  logic [width-1:0] data;
  logic [len_w-1:0] len;
  logic             ready;

  // child side drives the record
  modport prod (output valid, data, len, input ready);

  // parent side takes the record
  modport cons (input valid, data, len, output ready);

endinterface

// File: verilog/trace_pkg.sv
package trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // channel layout
  //////////////////////////////////////////////////////////////////////

  // number of logging channels feeding the packer
  localparam int num_chan = 4;

  // fixed record width of each channel, channel 0 first
  localparam int chan_width [num_chan] = '{8, 16, 8, 32};

  // bit offset of each channel inside the flat input vector
  localparam int chan_offset [num_chan] = '{0, 8, 24, 32};

  // packed word width, sum of all channel widths
  localparam int full_width = chan_offset[num_chan-1] + chan_width[num_chan-1];

  // enough bits to hold a length of 0 up to full_width
  localparam int len_width = $clog2(full_width + 1);

  // merge levels in the tree
  // also the ready delay and the pipeline latency
  localparam int tree_depth = 2;

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  // register map of the config block
  typedef enum logic [1:0] {
    // channel enable mask, read/write
    addr_enable = 2'd0,
    // packed word counter, read only
    addr_count  = 2'd1,
    // any write here zeroes the counter
    addr_clear  = 2'd2
  } cfg_addr_e;

endpackage
